// File: project.f
+incdir+include
hw/maxpool_pkg.sv
hw/pool_window_buffer.sv
hw/max3x3_core.sv
hw/pool_out_fifo.sv
hw/maxpool_3x3_top.sv
tb/maxpool_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing -j 0
TOP       = maxpool_tb
FILELIST  = project.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

# Build the simulation executable
compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Run and decide pass or fail from the log
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb/maxpool_tb.sv
`timescale 1ns/1ns
`include "maxpool_defines.svh"

module maxpool_tb
	import maxpool_pkg::*;
;

	localparam int W = `MAXP_IMAGE_WIDTH;
	localparam int H = `MAXP_IMAGE_HEIGHT;
	localparam int C = `MAXP_CHANNELS;
	localparam int DEPTH = `MAXP_FIFO_DEPTH;
	localparam int TIMEOUT_CYCLES = 2000;
	localparam logic [31:0] SEED = 32'h0300b90d;

	logic    clk = 1'b0;
	logic    reset;
	logic    valid_in;
	pixel_t  pxl_in;
	logic    rd_en;
	pooled_t out_data;
	logic    out_valid;
	logic    empty;
	logic    full;
	logic    overflow;

	// Reference frame indexed by row, column and channel
	pixel_t  frame_mem [H][W][C];
	pooled_t exp_q [$];
	pooled_t got_q [$];
	int pass_count = 0;
	int fail_count = 0;
	bit stalled = 1'b0;

	maxpool_3x3_top i_dut (
		.clk      (clk      ),
		.reset    (reset    ),
		.valid_in (valid_in ),
		.pxl_in   (pxl_in   ),
		.rd_en    (rd_en    ),
		.out_data (out_data ),
		.out_valid(out_valid),
		.empty    (empty    ),
		.full     (full     ),
		.overflow (overflow )
	);

	always #5 clk = ~clk;

	// Popped entries captured at the edge that ends their out_valid cycle
	always @(posedge clk) begin
		if (out_valid)
			got_q.push_back(out_data);
	end

	////////////////////
	// Run control
	////////////////////

	task automatic end_run();
		$display("checks passed %0d, failed %0d", pass_count, fail_count);
		if (fail_count == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	endtask

	// A stalled wait ends the remaining tests
	task automatic stall(input string test, input string what);
		$display("timeout: test %s stalled waiting for %s", test, what);
		fail_count++;
		stalled = 1'b1;
	endtask

	task automatic report_test(input string test, input int fails_before);
		$display("test %s done, %0d errors", test, fail_count - fails_before);
	endtask

	////////////////////
	// Compare tasks
	////////////////////

	task automatic check_pooled(input pooled_t got, input pooled_t exp, input string what);
		if (got !== exp) begin
			$display("error at %0t: %s max/chan/last got %0d/%0d/%0b expected %0d/%0d/%0b",
				$time, what, got.max_val, got.chan, got.last, exp.max_val, exp.chan, exp.last);
			fail_count++;
		end else begin
			pass_count++;
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
			fail_count++;
		end else begin
			pass_count++;
		end
	endtask

	// Count first and then each entry in order
	task automatic compare_results(input string test);
		if (got_q.size() != exp_q.size()) begin
			$display("error at %0t: %s produced %0d results, expected %0d",
				$time, test, got_q.size(), exp_q.size());
			fail_count++;
		end
		for (int i = 0; i < exp_q.size() && i < got_q.size(); i++)
			check_pooled(got_q[i], exp_q[i], $sformatf("%s result %0d", test, i));
	endtask

	////////////////////
	// Reference model
	////////////////////

	// Stride 2 windows in position order then channel
	task automatic build_expected();
		pooled_t e;
		pixel_t  m;
		for (int r = 2; r < H; r += 2) begin
			for (int c = 2; c < W; c += 2) begin
				for (int ch = 0; ch < C; ch++) begin
					m = '0;
					for (int dr = 0; dr < 3; dr++) begin
						for (int dc = 0; dc < 3; dc++) begin
							if (frame_mem[r - 2 + dr][c - 2 + dc][ch] > m)
								m = frame_mem[r - 2 + dr][c - 2 + dc][ch];
						end
					end
					e.max_val = m;
					e.chan = chan_t'(ch);
					e.last = 1'b0;
					exp_q.push_back(e);
				end
			end
		end
		// Frame end marker on the final entry
		e = exp_q.pop_back();
		e.last = 1'b1;
		exp_q.push_back(e);
	endtask

	// Pattern fills
	task automatic fill_ramp();
		for (int r = 0; r < H; r++)
			for (int c = 0; c < W; c++)
				for (int ch = 0; ch < C; ch++)
					frame_mem[r][c][ch] = pixel_t'(r + c + ch);
	endtask

	task automatic fill_random();
		for (int r = 0; r < H; r++)
			for (int c = 0; c < W; c++)
				for (int ch = 0; ch < C; ch++)
					frame_mem[r][c][ch] = pixel_t'($urandom);
	endtask

	// Small values on channel 0 and large ones on channel 1
	task automatic fill_split();
		for (int r = 0; r < H; r++)
			for (int c = 0; c < W; c++)
				for (int ch = 0; ch < C; ch++)
					frame_mem[r][c][ch] = (ch == 0) ? pixel_t'($urandom % 64)
						: pixel_t'(128 + ($urandom % 128));
	endtask

	////////////////////
	// Drivers and waits
	////////////////////

	// Leaves the run at a falling edge with reset low
	task automatic run_reset();
		@(negedge clk);
		reset = 1'b1;
		valid_in = 1'b0;
		rd_en = 1'b0;
		repeat (4) @(negedge clk);
		reset = 1'b0;
		exp_q.delete();
		got_q.delete();
	endtask

	// Raster order with valid left high after the last pixel
	task automatic send_frame(input bit gaps);
		int n;
		for (int r = 0; r < H; r++) begin
			for (int c = 0; c < W; c++) begin
				for (int ch = 0; ch < C; ch++) begin
					@(negedge clk);
					valid_in = 1'b1;
					pxl_in = frame_mem[r][c][ch];
					if (gaps) begin
						n = 1 + int'($urandom % 3);
						repeat (n) begin
							@(negedge clk);
							valid_in = 1'b0;
						end
					end
				end
			end
		end
	endtask

	task automatic go_idle();
		@(negedge clk);
		valid_in = 1'b0;
	endtask

	task automatic wait_results(input int n, input string test);
		int cycles;
		cycles = 0;
		while (got_q.size() < n && cycles < TIMEOUT_CYCLES) begin
			@(negedge clk);
			cycles++;
		end
		if (got_q.size() < n)
			stall(test, "results");
	endtask

	// FIFO empty and no pop in flight
	task automatic wait_settled(input string test);
		int cycles;
		cycles = 0;
		while (!(empty && !out_valid) && cycles < TIMEOUT_CYCLES) begin
			@(negedge clk);
			cycles++;
		end
		if (!(empty && !out_valid))
			stall(test, "the FIFO to drain");
	endtask

	task automatic wait_overflow(input string test);
		int cycles;
		cycles = 0;
		while (!overflow && cycles < TIMEOUT_CYCLES) begin
			@(negedge clk);
			cycles++;
		end
		if (!overflow)
			stall(test, "overflow");
	endtask

	////////////////////
	// Directed tests
	////////////////////

	task automatic test_reset_state();
		int fails;
		fails = fail_count;
		run_reset();
		check_flag(out_valid, 1'b0, "out_valid after reset");
		check_flag(overflow, 1'b0, "overflow after reset");
		check_flag(empty, 1'b1, "empty after reset");
		report_test("reset_state", fails);
	endtask

	// Shared body for the streaming tests with rd_en high throughout
	task automatic stream_frames(input string test, input int frames, input bit gaps);
		rd_en = 1'b1;
		for (int f = 0; f < frames; f++) begin
			if (test == "split")
				fill_split();
			else if (test == "ramp")
				fill_ramp();
			else
				fill_random();
			build_expected();
			send_frame(gaps);
		end
		go_idle();
		wait_results(exp_q.size(), test);
		if (stalled)
			return;
		wait_settled(test);
		if (stalled)
			return;
		rd_en = 1'b0;
		compare_results(test);
	endtask

	task automatic test_ramp();
		int fails;
		fails = fail_count;
		run_reset();
		stream_frames("ramp", 1, 1'b0);
		report_test("ramp", fails);
	endtask

	task automatic test_gaps();
		int fails;
		fails = fail_count;
		run_reset();
		stream_frames("gaps", 1, 1'b1);
		report_test("gaps", fails);
	endtask

	// Counter wrap and line buffer reuse
	task automatic test_two_frames();
		int fails;
		fails = fail_count;
		run_reset();
		stream_frames("two_frames", 2, 1'b0);
		report_test("two_frames", fails);
	endtask

	task automatic test_split();
		int fails;
		fails = fail_count;
		run_reset();
		stream_frames("split", 1, 1'b0);
		// Large values only ever tagged channel 1
		for (int i = 0; i < got_q.size(); i++)
			check_flag(got_q[i].max_val >= pixel_t'(128), got_q[i].chan == chan_t'(1),
				$sformatf("split result %0d value range", i));
		report_test("split", fails);
	endtask

	task automatic test_backpressure();
		int fails;
		fails = fail_count;
		run_reset();
		fill_random();
		build_expected();
		send_frame(1'b0);
		go_idle();
		wait_overflow("backpressure");
		if (stalled)
			return;
		// Give the last result time to reach the FIFO
		repeat (4) @(negedge clk);
		check_flag(full, 1'b1, "full before drain");
		check_flag(overflow, 1'b1, "overflow before drain");
		check_flag(empty, 1'b0, "empty before drain");
		// Only the first DEPTH results survive
		while (exp_q.size() > DEPTH)
			void'(exp_q.pop_back());
		rd_en = 1'b1;
		wait_results(DEPTH, "backpressure");
		if (stalled)
			return;
		// Nothing stored past the sixteenth entry
		check_flag(empty, 1'b1, "empty after last pop");
		wait_settled("backpressure");
		if (stalled)
			return;
		rd_en = 1'b0;
		compare_results("backpressure");
		check_flag(full, 1'b0, "full after drain");
		report_test("backpressure", fails);
	endtask

	initial begin
		reset = 1'b1;
		valid_in = 1'b0;
		pxl_in = '0;
		rd_en = 1'b0;
		void'($urandom(SEED));
		test_reset_state();
		if (!stalled)
			test_ramp();
		if (!stalled)
			test_gaps();
		if (!stalled)
			test_two_frames();
		if (!stalled)
			test_split();
		if (!stalled)
			test_backpressure();
		end_run();
	end

endmodule

// File: hw/maxpool_3x3_top.sv
`timescale 1ns/1ns
`include "maxpool_defines.svh"

module maxpool_3x3_top
	import maxpool_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    valid_in,
	input  pixel_t  pxl_in,
	input  logic    rd_en,
	output pooled_t out_data,
	output logic    out_valid,
	output logic    empty,
	output logic    full,
	output logic    overflow
);

	// Window buffer to core
	window_t win;
	logic    win_valid;
	logic    win_last;

	// Core to FIFO
	pooled_t res;
	logic    res_valid;

	pool_window_buffer i_window_buffer (
		.clk      (clk      ),
		.reset    (reset    ),
		.valid_in (valid_in ),
		.pxl_in   (pxl_in   ),
		.win      (win      ),
		.win_valid(win_valid),
		.last     (win_last )
	);

	max3x3_core i_core (
		.clk      (clk      ),
		.reset    (reset    ),
		.win_valid(win_valid),
		.win      (win      ),
		.last_in  (win_last ),
		.res      (res      ),
		.res_valid(res_valid)
	);

	// Pooled results wait here for the outside read strobe
	pool_out_fifo #(
		.T    (pooled_t        ),
		.DEPTH(`MAXP_FIFO_DEPTH)
	) i_out_fifo (
		.clk      (clk      ),
		.reset    (reset    ),
		.wr_en    (res_valid),
		.wr_data  (res      ),
		.rd_en    (rd_en    ),
		.out_data (out_data ),
		.out_valid(out_valid),
		.empty    (empty    ),
		.full     (full     ),
		.overflow (overflow )
	);

endmodule

// File: hw/pool_out_fifo.sv
`timescale 1ns/1ns
`include "maxpool_defines.svh"

module pool_out_fifo
	import maxpool_pkg::*;
#(
	parameter type T = pooled_t,
	parameter int DEPTH = `MAXP_FIFO_DEPTH
) (
	input  logic clk,
	input  logic reset,
	input  logic wr_en,
	input  T     wr_data,
	input  logic rd_en,
	output T     out_data,
	output logic out_valid,
	output logic empty,
	output logic full,
	output logic overflow
);

	localparam int AW = $clog2(DEPTH);

	// Circular storage
	T mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;

	logic do_rd;
	logic do_wr;

	assign empty = (count == '0);
	assign full = (count == (AW + 1)'(DEPTH));

	// A pop in the same cycle frees room for a write into a full FIFO
	assign do_rd = rd_en && !empty;
	assign do_wr = wr_en && (!full || do_rd);

	////////////////////
	// Pointers and count
	////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			out_valid <= 1'b0;
			overflow <= 1'b0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			out_valid <= do_rd;
			// Dropped write, sticky until reset
			if (wr_en && !do_wr)
				overflow <= 1'b1;
		end
	end

	// Storage and registered read port
	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
		if (do_rd)
			out_data <= mem[rd_ptr];
	end

endmodule

// File: hw/max3x3_core.sv
`timescale 1ns/1ns
`include "maxpool_defines.svh"

module max3x3_core
	import maxpool_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    win_valid,
	input  window_t win,
	input  logic    last_in,
	output pooled_t res,
	output logic    res_valid
);

	// Stage one registers
	pixel_t row_max [3];
	chan_t  s1_chan;
	logic   s1_last;
	logic   s1_valid;

	// Largest of three unsigned pixels
	function automatic pixel_t max3(input pixel_t a, input pixel_t b, input pixel_t c);
		pixel_t m;
		m = a;
		if (b > m)
			m = b;
		if (c > m)
			m = c;
		return m;
	endfunction

	////////////////////
	// Stage one
	////////////////////

	// Row maxima, a new window every cycle
	always_ff @(posedge clk) begin
		row_max[0] <= max3(win.p00, win.p01, win.p02);
		row_max[1] <= max3(win.p10, win.p11, win.p12);
		row_max[2] <= max3(win.p20, win.p21, win.p22);
		s1_chan <= win.chan;
		s1_last <= last_in;
	end

	////////////////////
	// Stage two
	////////////////////

	always_ff @(posedge clk) begin
		res.max_val <= max3(row_max[0], row_max[1], row_max[2]);
		res.chan <= s1_chan;
		res.last <= s1_last;
	end

	// Valid travels beside the data
	always_ff @(posedge clk) begin
		if (reset) begin
			s1_valid <= 1'b0;
			res_valid <= 1'b0;
		end else begin
			s1_valid <= win_valid;
			res_valid <= s1_valid;
		end
	end

endmodule

// File: hw/pool_window_buffer.sv
`timescale 1ns/1ns
`include "maxpool_defines.svh"

module pool_window_buffer
	import maxpool_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    valid_in,
	input  pixel_t  pxl_in,
	output window_t win,
	output logic    win_valid,
	output logic    last
);

	////////////////////
	// Geometry
	////////////////////

	localparam int W = `MAXP_IMAGE_WIDTH;
	localparam int H = `MAXP_IMAGE_HEIGHT;
	localparam int C = `MAXP_CHANNELS;
	localparam int COL_W = $clog2(W);
	localparam int ROW_W = $clog2(H);
	localparam int LB_DEPTH = W * C;
	localparam int AW = $clog2(LB_DEPTH);
	// Last kept window sits on the highest even row and column
	localparam int LAST_ROW = (H - 1) - ((H - 1) % 2);
	localparam int LAST_COL = (W - 1) - ((W - 1) % 2);

	// Position of the incoming pixel
	chan_t            chan_cnt;
	logic [COL_W-1:0] col_cnt;
	logic [ROW_W-1:0] row_cnt;

	// Line buffers, lb1 one row up, lb2 two rows up
	pixel_t lb1 [LB_DEPTH];
	pixel_t lb2 [LB_DEPTH];
	logic [AW-1:0] lb_addr;
	pixel_t lb1_rd;
	pixel_t lb2_rd;

	// Per channel row shift registers, tap 0 is oldest column
	pixel_t sh_top [C][2];
	pixel_t sh_mid [C][2];
	pixel_t sh_bot [C][2];

	window_t win_next;
	logic    keep;
	logic    frame_last;

	////////////////////
	// Position counters
	////////////////////

	// Channel fastest, then column, then row
	always_ff @(posedge clk) begin
		if (reset) begin
			chan_cnt <= '0;
			col_cnt <= '0;
			row_cnt <= '0;
		end else if (valid_in) begin
			if (chan_cnt == chan_t'(C - 1)) begin
				chan_cnt <= '0;
				if (col_cnt == COL_W'(W - 1)) begin
					col_cnt <= '0;
					// Frame end wraps straight into next frame
					if (row_cnt == ROW_W'(H - 1))
						row_cnt <= '0;
					else
						row_cnt <= row_cnt + 1'b1;
				end else begin
					col_cnt <= col_cnt + 1'b1;
				end
			end else begin
				chan_cnt <= chan_cnt + 1'b1;
			end
		end
	end

	////////////////////
	// Line buffers
	////////////////////

	// One slot per column and channel
	assign lb_addr = AW'(int'(col_cnt) * C + int'(chan_cnt));
	assign lb1_rd = lb1[lb_addr];
	assign lb2_rd = lb2[lb_addr];

	// Old row moves down a buffer as the new pixel lands
	always_ff @(posedge clk) begin
		if (valid_in) begin
			lb1[lb_addr] <= pxl_in;
			lb2[lb_addr] <= lb1_rd;
		end
	end

	// Only the active channel's columns shift
	always_ff @(posedge clk) begin
		if (valid_in) begin
			sh_top[chan_cnt][0] <= sh_top[chan_cnt][1];
			sh_top[chan_cnt][1] <= lb2_rd;
			sh_mid[chan_cnt][0] <= sh_mid[chan_cnt][1];
			sh_mid[chan_cnt][1] <= lb1_rd;
			sh_bot[chan_cnt][0] <= sh_bot[chan_cnt][1];
			sh_bot[chan_cnt][1] <= pxl_in;
		end
	end

	////////////////////
	// Window assembly
	////////////////////

	// Two stored columns plus the column arriving now
	always_comb begin
		win_next.p00 = sh_top[chan_cnt][0];
		win_next.p01 = sh_top[chan_cnt][1];
		win_next.p02 = lb2_rd;
		win_next.p10 = sh_mid[chan_cnt][0];
		win_next.p11 = sh_mid[chan_cnt][1];
		win_next.p12 = lb1_rd;
		win_next.p20 = sh_bot[chan_cnt][0];
		win_next.p21 = sh_bot[chan_cnt][1];
		win_next.p22 = pxl_in;
		win_next.chan = chan_cnt;
	end

	// Stride 2, bottom-right corner on even row and column past the border
	assign keep = !row_cnt[0] && (row_cnt >= ROW_W'(2))
		&& !col_cnt[0] && (col_cnt >= COL_W'(2));
	assign frame_last = (row_cnt == ROW_W'(LAST_ROW)) && (col_cnt == COL_W'(LAST_COL))
		&& (chan_cnt == chan_t'(C - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			win_valid <= 1'b0;
			last <= 1'b0;
		end else begin
			win_valid <= valid_in && keep;
			last <= valid_in && keep && frame_last;
		end
	end

	// Window payload, no reset needed
	always_ff @(posedge clk) begin
		if (valid_in)
			win <= win_next;
	end

endmodule

// File: hw/maxpool_pkg.sv
`include "maxpool_defines.svh"

package maxpool_pkg;

	////////////////////
	// Scalar types
	////////////////////

	// Channel tag width, at least one bit
	localparam int CHAN_W = (`MAXP_CHANNELS > 1) ? $clog2(`MAXP_CHANNELS) : 1;

	typedef logic [`MAXP_DATA_WIDTH-1:0] pixel_t;
	typedef logic [CHAN_W-1:0] chan_t;

	////////////////////
	// Stream payloads
	////////////////////

	// 3x3 window, row then column, p22 newest
	typedef struct packed {
		pixel_t p00;
		pixel_t p01;
		pixel_t p02;
		pixel_t p10;
		pixel_t p11;
		pixel_t p12;
		pixel_t p20;
		pixel_t p21;
		pixel_t p22;
		chan_t  chan;
	} window_t;

	// One pooled result, last marks frame end
	typedef struct packed {
		pixel_t max_val;
		chan_t  chan;
		logic   last;
	} pooled_t;

endpackage

// File: include/maxpool_defines.svh
`ifndef MAXPOOL_DEFINES_SVH
`define MAXPOOL_DEFINES_SVH

////////////////////
// Pixel format
////////////////////

// Bits per pixel, unsigned
`define MAXP_DATA_WIDTH 8

////////////////////
// Frame geometry
////////////////////

`define MAXP_IMAGE_WIDTH 9
`define MAXP_IMAGE_HEIGHT 9
// Channels interleaved within one pixel
`define MAXP_CHANNELS 2

// Output FIFO entries, power of two
`define MAXP_FIFO_DEPTH 16

`endif
